// File: files.f
source/load_pkg.sv
source/load_ctrl.sv
source/load_queue.sv
source/load_align.sv
source/load_unit.sv
sim/load_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the load unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module load_unit_tb -o load_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/load_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation passed"
exit 0

// File: sim/load_unit_tb.sv
// load unit testbench
`timescale 1ns/1ps
`default_nettype none

module load_unit_tb import load_pkg::*;;

    localparam int unsigned DEPTH = 2;
    // 300 loads at 20 cycles each
    localparam int LIMIT = 300 * 20;

    logic            clk_i;
    logic            rst_ni;
    logic            flush_i;
    load_req_t       req_i;
    logic            valid_i;
    logic            ready_o;
    logic            valid_o;
    load_resp_t      resp_o;
    logic            translation_req_o;
    logic [XLEN-1:0] vaddr_o;
    logic [XLEN-1:0] paddr_i;
    logic            translation_valid_i;
    logic            page_offset_matches_i;
    dcache_req_t     dcache_o;
    logic            data_gnt_i;
    logic            data_rvalid_i;
    logic [XLEN-1:0] data_rdata_i;

    // model state
    logic [31:0]     lfsr_q;
    int              conf_left;
    int              miss_left;
    int              gnt_left;
    logic            gnt_ok;
    int              inflight;
    int              max_inflight;
    int              kill_seen;
    int              flush_count;
    logic [2:0]      next_id;
    logic [55:0]     addr_q[$];
    int              due_q[$];
    logic [2:0]      exp_id_q[$];
    logic [63:0]     exp_res_q[$];

    // translation flips bit 40 and misses while miss_left counts down
    assign paddr_i               = vaddr_o ^ (64'h1 << 40);
    assign translation_valid_i   = (miss_left == 0);
    assign page_offset_matches_i = valid_i && (conf_left != 0);
    assign data_gnt_i            = dcache_o.data_req && gnt_ok;

    load_unit #(
        .QUEUE_DEPTH ( DEPTH )
    ) i_dut (
        .clk_i                 ( clk_i                 ),
        .rst_ni                ( rst_ni                ),
        .flush_i               ( flush_i               ),
        .req_i                 ( req_i                 ),
        .valid_i               ( valid_i               ),
        .ready_o               ( ready_o               ),
        .valid_o               ( valid_o               ),
        .resp_o                ( resp_o                ),
        .translation_req_o     ( translation_req_o     ),
        .vaddr_o               ( vaddr_o               ),
        .paddr_i               ( paddr_i               ),
        .translation_valid_i   ( translation_valid_i   ),
        .page_offset_matches_i ( page_offset_matches_i ),
        .dcache_o              ( dcache_o              ),
        .data_gnt_i            ( data_gnt_i            ),
        .data_rvalid_i         ( data_rvalid_i         ),
        .data_rdata_i          ( data_rdata_i          )
    );

    // ------------------------------
    // helpers
    // ------------------------------
    // galois lfsr stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // memory contents from an odd multiplier so every word address differs
    function automatic logic [63:0] mem_word(input logic [55:0] waddr);
        return 64'(waddr) * 64'h9E37_79B9_7F4A_7C15;
    endfunction

    function automatic int op_size(input load_op_e op);
        case (op)
            LD: return 8;
            LW, LWU: return 4;
            LH, LHU: return 2;
            default: return 1;
        endcase
    endfunction

    function automatic logic [7:0] be_of(input load_op_e op, input logic [2:0] off);
        logic [7:0] m;
        m = 8'((1 << op_size(op)) - 1);
        return m << off;
    endfunction

    // expected load result from operator, byte offset and memory word
    function automatic logic [63:0] ref_result(input load_op_e op, input logic [2:0] off,
                                               input logic [63:0] w);
        logic [63:0] s;
        s = w >> (32'(off) * 8);
        case (op)
            LW: return 64'($signed(s[31:0]));
            LWU: return 64'(s[31:0]);
            LH: return 64'($signed(s[15:0]));
            LHU: return 64'(s[15:0]);
            LB: return 64'($signed(s[7:0]));
            LBU: return 64'(s[7:0]);
            default: return w;
        endcase
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // ------------------------------
    // clock and timeout
    // ------------------------------
    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk_i);
            cycles++;
            if (cycles > LIMIT) begin
                $display("ERRORS FOUND");
                $fatal(1, "timeout, run went past %0d cycles", LIMIT);
            end
        end
    end

    // ------------------------------
    // cache model
    // ------------------------------
    // sample mid cycle and drive 1 ns after the edge
    initial begin : cache_model
        logic        had_gnt;
        logic        gnt_now;
        logic        req_held;
        logic        miss_gnt;
        logic        rv_next;
        logic [11:0] idx_prev;
        logic [63:0] rd_next;
        int          cyc;
        int          left_next;
        had_gnt       = 1'b0;
        req_held      = 1'b0;
        miss_gnt      = 1'b0;
        idx_prev      = '0;
        cyc           = 0;
        gnt_left      = 0;
        gnt_ok        = 1'b1;
        inflight      = 0;
        max_inflight  = 0;
        data_rvalid_i = 1'b0;
        data_rdata_i  = '0;
        forever begin
            @(negedge clk_i);
            cyc++;
            if (dcache_o.data_req && !data_gnt_i) begin
                check_eq(64'(ready_o), 64'd0, "ready_o while grant withheld");
            end
            // a withheld request stays up until it is granted
            if (req_held && !flush_i) begin
                check_eq(64'(dcache_o.data_req), 64'd1,
                         "data_req dropped while grant withheld");
            end
            // a request granted on a tlb miss is killed in the next cycle
            if (miss_gnt) begin
                check_eq(64'(dcache_o.kill_req && dcache_o.tag_valid), 64'd1,
                         "granted miss not killed");
            end
            // tag phase of last cycle's grant
            if (dcache_o.tag_valid && had_gnt && !dcache_o.kill_req) begin
                addr_q.push_back({dcache_o.tag, idx_prev});
                due_q.push_back(cyc + int'(rand_bits(2)));
            end
            gnt_now = dcache_o.data_req && data_gnt_i;
            if (gnt_now && ready_o) begin
                inflight++;
            end
            if (data_rvalid_i) begin
                inflight--;
            end
            if (inflight > max_inflight) begin
                max_inflight = inflight;
            end
            req_held = dcache_o.data_req && !data_gnt_i && translation_valid_i;
            miss_gnt = gnt_now && !translation_valid_i;
            had_gnt  = gnt_now;
            idx_prev = dcache_o.index;
            left_next = gnt_left;
            if (gnt_now) begin
                left_next = int'(rand_bits(2));
            end else if (dcache_o.data_req && gnt_left > 0) begin
                left_next = gnt_left - 1;
            end
            rv_next = 1'b0;
            rd_next = '0;
            if (addr_q.size() != 0 && due_q[0] <= cyc) begin
                rv_next = 1'b1;
                rd_next = mem_word(addr_q[0] >> 3);
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
            end
            @(posedge clk_i);
            #1;
            gnt_left      = left_next;
            gnt_ok        = (left_next == 0) && (inflight < int'(DEPTH));
            data_rvalid_i = rv_next;
            data_rdata_i  = rd_next;
        end
    end

    // ------------------------------
    // scoreboard
    // ------------------------------
    initial begin : compare
        forever begin
            @(negedge clk_i);
            if (valid_o) begin
                if (exp_id_q.size() == 0) begin
                    $display("valid_o raised at %0t ns with no load expected", $time);
                    $display("ERRORS FOUND");
                    $fatal(1, "unexpected response");
                end
                check_eq(64'(resp_o.trans_id), 64'(exp_id_q.pop_front()), "trans_id");
                check_eq(resp_o.result, exp_res_q.pop_front(), "load result");
            end
            // flushed loads must stay silent
            if (flush_i) begin
                exp_id_q.delete();
                exp_res_q.delete();
            end
            if (valid_i && ready_o) begin
                exp_id_q.push_back(req_i.trans_id);
                exp_res_q.push_back(ref_result(req_i.operator, req_i.vaddr[2:0],
                    mem_word(56'((req_i.vaddr ^ (64'h1 << 40)) >> 3))));
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    // one clock with checks mid cycle and stall counter updates after the edge
    task automatic next_cycle(output logic rdy);
        logic dec_conf;
        logic dec_miss;
        @(negedge clk_i);
        rdy      = ready_o;
        dec_conf = page_offset_matches_i;
        dec_miss = translation_req_o && !translation_valid_i;
        if (page_offset_matches_i) begin
            check_eq(64'(dcache_o.data_req), 64'd0, "data_req during offset conflict");
            check_eq(64'(ready_o), 64'd0, "ready_o during offset conflict");
        end
        // byte lanes of the operator at its offset
        if (dcache_o.data_req) begin
            check_eq(64'(dcache_o.be), 64'(be_of(req_i.operator, req_i.vaddr[2:0])),
                     "byte enables");
        end
        if (!valid_i) begin
            check_eq(64'(translation_req_o), 64'd0, "translation request without a load");
        end
        if (dcache_o.kill_req && dcache_o.tag_valid) begin
            kill_seen++;
        end
        @(posedge clk_i);
        #1;
        if (dec_conf) begin
            conf_left--;
        end
        if (dec_miss) begin
            miss_left--;
        end
    endtask

    task automatic run_load(input load_op_e op, input logic [2:0] off);
        logic        rdy;
        logic [63:0] r;
        r = rand_bits(45);
        req_i.operator = op;
        req_i.trans_id = next_id;
        req_i.vaddr    = {16'h0, r[44:0], off};
        req_i.be       = be_of(op, off);
        next_id++;
        conf_left = int'(rand_bits(2)) % 3;
        miss_left = (rand_bits(2) == 0) ? 1 + int'(rand_bits(2)) % 3 : 0;
        valid_i   = 1'b1;
        do begin
            next_cycle(rdy);
        end while (!rdy);
    endtask

    // kill everything in flight and wait for the unit to take loads again
    task automatic flush_now();
        logic rdy;
        valid_i   = 1'b0;
        conf_left = 0;
        miss_left = 0;
        flush_i   = 1'b1;
        next_cycle(rdy);
        flush_i = 1'b0;
        do begin
            next_cycle(rdy);
        end while (!rdy);
        flush_count++;
    endtask

    initial begin : main
        logic       rdy;
        int         k;
        logic [2:0] off;
        lfsr_q      = 32'd73888;
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        valid_i     = 1'b0;
        req_i       = '0;
        conf_left   = 0;
        miss_left   = 0;
        kill_seen   = 0;
        flush_count = 0;
        next_id     = '0;
        repeat (3) @(posedge clk_i);
        // outputs held idle while in reset
        @(negedge clk_i);
        check_eq(64'({valid_o, dcache_o.data_req, dcache_o.tag_valid, dcache_o.kill_req,
                      translation_req_o}), 64'd0, "outputs active during reset");
        @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // every operator at every aligned offset
        for (int op = 0; op < 7; op++) begin
            for (int o = 0; o < 8; o += op_size(load_op_e'(op))) begin
                run_load(load_op_e'(op), 3'(o));
            end
        end

        // random mix with the odd flush
        for (int i = 0; i < 250; i++) begin
            if (rand_bits(4) == 0) begin
                flush_now();
            end
            k   = int'(rand_bits(3)) % 7;
            off = 3'(rand_bits(3)) & 3'(8 - op_size(load_op_e'(k)));
            run_load(load_op_e'(k), off);
        end

        // drain
        valid_i = 1'b0;
        do begin
            next_cycle(rdy);
        end while (exp_id_q.size() != 0 || addr_q.size() != 0 || inflight != 0);

        check_eq(64'(kill_seen > 0), 64'd1, "translation abort never seen");
        check_eq(64'(max_inflight >= 2), 64'd1, "two loads never in flight");
        check_eq(64'(flush_count > 0), 64'd1, "no flush issued");
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/load_align.sv
// load data alignment and extension
`timescale 1ns/1ps
`default_nettype none

module load_align import load_pkg::*; (
    input  queue_entry_t    head_i,
    input  logic [XLEN-1:0] data_rdata_i,
    output logic [XLEN-1:0] result_o
);

    // returned word moved down so the field starts at bit 0
    logic [XLEN-1:0] shifted;

    assign shifted = data_rdata_i >> {head_i.offset, 3'b000};

    // ------------------------------
    // field select and extend
    // ------------------------------
    always_comb begin
        case (head_i.operator)
            // word, signed and unsigned
            LW: begin
                result_o = {{32{shifted[31]}}, shifted[31:0]};
            end
            LWU: begin
                result_o = {32'b0, shifted[31:0]};
            end
            // half word
            LH: begin
                result_o = {{48{shifted[15]}}, shifted[15:0]};
            end
            LHU: begin
                result_o = {48'b0, shifted[15:0]};
            end
            // byte
            LB: begin
                result_o = {{56{shifted[7]}}, shifted[7:0]};
            end
            LBU: begin
                result_o = {56'b0, shifted[7:0]};
            end
            // double is always aligned, whole word as is
            default: begin
                result_o = data_rdata_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/load_ctrl.sv
// load request controller
`timescale 1ns/1ps
`default_nettype none

module load_ctrl import load_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    // load from issue
    input  load_req_t       req_i,
    input  logic            valid_i,
    output logic            ready_o,
    // address translation
    output logic            translation_req_o,
    input  logic [XLEN-1:0] paddr_i,
    input  logic            translation_valid_i,
    // store buffer check
    input  logic            page_offset_matches_i,
    // data cache
    output dcache_req_t     dcache_o,
    input  logic            data_gnt_i,
    input  logic            data_rvalid_i,
    // response queue
    output logic            push_o,
    output queue_entry_t    entry_o,
    input  logic            empty_i
);

    load_state_e      state_q, state_d;
    // physical tag, sent the cycle after the grant
    logic [TAG_W-1:0] tag_q;
    logic             tag_load;
    // try to start the load sitting on req_i
    logic             issue;

    // queue entry straight from the request
    assign entry_o.trans_id = req_i.trans_id;
    assign entry_o.offset   = req_i.vaddr[2:0];
    assign entry_o.operator = req_i.operator;
    assign entry_o.killed   = 1'b0;

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_d           = state_q;
        ready_o           = 1'b0;
        translation_req_o = 1'b0;
        push_o            = 1'b0;
        tag_load          = 1'b0;
        issue             = 1'b0;
        // index comes from the untranslated address
        dcache_o.index     = req_i.vaddr[PAGE_OFFSET_W-1:0];
        dcache_o.tag       = tag_q;
        dcache_o.be        = req_i.be;
        dcache_o.data_req  = 1'b0;
        dcache_o.tag_valid = 1'b0;
        dcache_o.kill_req  = 1'b0;

        case (state_q)
            IDLE: begin
                issue = 1'b1;
            end
            SEND_TAG: begin
                // tag for last cycle's grant, next load may overlap
                dcache_o.tag_valid = 1'b1;
                issue              = 1'b1;
            end
            WAIT_GNT: begin
                // hold the request until the cache takes it
                dcache_o.data_req = 1'b1;
                if (data_gnt_i) begin
                    push_o  = 1'b1;
                    ready_o = 1'b1;
                    state_d = SEND_TAG;
                end
            end
            ABORT_TRANSLATION: begin
                // drop whatever the cache accepted on the miss
                dcache_o.tag_valid = 1'b1;
                dcache_o.kill_req  = 1'b1;
                translation_req_o  = valid_i;
                if (!valid_i) begin
                    state_d = IDLE;
                end else if (translation_valid_i) begin
                    issue = 1'b1;
                end
            end
            WAIT_FLUSH: begin
                // no new loads until the old ones are gone
                if (empty_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // ------------------------------
        // shared issue path
        // ------------------------------
        if (issue) begin
            state_d = IDLE;
            if (!valid_i) begin
                ready_o = 1'b1;
            end else begin
                // translate early, even if a store conflict stalls us
                translation_req_o = 1'b1;
                if (!page_offset_matches_i) begin
                    dcache_o.data_req = 1'b1;
                    if (!translation_valid_i) begin
                        // tlb miss, kill next cycle and wait for the walk
                        state_d = ABORT_TRANSLATION;
                    end else begin
                        tag_load = 1'b1;
                        if (data_gnt_i) begin
                            push_o  = 1'b1;
                            ready_o = 1'b1;
                            state_d = SEND_TAG;
                        end else begin
                            state_d = WAIT_GNT;
                        end
                    end
                end
            end
        end

        // flush drops the current request, queued loads get killed in the queue
        if (flush_i) begin
            translation_req_o = 1'b0;
            dcache_o.data_req = 1'b0;
            push_o            = 1'b0;
            ready_o           = 1'b0;
            tag_load          = 1'b0;
            state_d           = (!empty_i || data_rvalid_i) ? WAIT_FLUSH : IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // paddr[55:12], taken in the issue cycle
    always_ff @(posedge clk_i) begin
        if (tag_load) begin
            tag_q <= paddr_i[PAGE_OFFSET_W+TAG_W-1:PAGE_OFFSET_W];
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    // a queued load is granted now and tagged exactly one cycle later
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_o |-> data_gnt_i ##1 dcache_o.tag_valid)
        else $error("load pushed without grant or not tagged next cycle");

    // a kill is a tag phase and never hits a load that was just queued
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_o.kill_req |-> dcache_o.tag_valid && !$past(push_o))
        else $error("kill_req outside tag phase or after a push");

endmodule

`default_nettype wire

// File: source/load_pkg.sv
// load unit shared types
`default_nettype none

package load_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int unsigned XLEN          = 64;
    // cache index, same bits as the page offset
    localparam int unsigned PAGE_OFFSET_W = 12;
    // physical tag covers paddr[55:12]
    localparam int unsigned TAG_W         = 44;
    localparam int unsigned TRANS_ID_W    = 3;

    // load operators, double first
    typedef enum logic [2:0] {LD, LW, LWU, LH, LHU, LB, LBU} load_op_e;

    // controller states
    typedef enum logic [2:0] {IDLE, WAIT_GNT, SEND_TAG, ABORT_TRANSLATION, WAIT_FLUSH} load_state_e;

    // incoming load from issue
    typedef struct packed {
        load_op_e               operator;
        logic [TRANS_ID_W-1:0]  trans_id;
        logic [XLEN-1:0]        vaddr;
        logic [XLEN/8-1:0]      be;
    } load_req_t;

    // finished load back to writeback
    typedef struct packed {
        logic [TRANS_ID_W-1:0]  trans_id;
        logic [XLEN-1:0]        result;
    } load_resp_t;

    // request side of the data cache port
    typedef struct packed {
        logic [PAGE_OFFSET_W-1:0] index;
        logic [TAG_W-1:0]         tag;
        logic [XLEN/8-1:0]        be;
        logic                     data_req;
        logic                     tag_valid;
        logic                     kill_req;
    } dcache_req_t;

    // one outstanding load, enough to align its data later
    typedef struct packed {
        logic [TRANS_ID_W-1:0]  trans_id;
        logic [2:0]             offset;
        load_op_e               operator;
        logic                   killed;
    } queue_entry_t;

endpackage

`default_nettype wire

// File: source/load_queue.sv
// in-flight load queue
`timescale 1ns/1ps
`default_nettype none

module load_queue import load_pkg::*; #(
    parameter int unsigned QUEUE_DEPTH = 2
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    input  logic         push_i,
    input  queue_entry_t entry_i,
    input  logic         data_rvalid_i,
    output queue_entry_t head_o,
    output logic         empty_o,
    output logic         valid_o
);

    localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

    queue_entry_t [QUEUE_DEPTH-1:0] mem_q;
    logic [PTR_W-1:0]               wr_ptr_q;
    logic [PTR_W-1:0]               rd_ptr_q;
    logic [CNT_W-1:0]               count_q;
    logic                           full;
    logic                           pop;

    // responses come back in order, so every rvalid retires the head
    assign pop     = data_rvalid_i;
    assign empty_o = (count_q == '0);
    assign full    = (count_q == CNT_W'(QUEUE_DEPTH));
    assign head_o  = mem_q[rd_ptr_q];
    // killed loads are eaten here
    assign valid_o = pop && !head_o.killed && !flush_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop);
        end
    end

    // entry storage, flush marks everything killed
    always_ff @(posedge clk_i) begin
        if (flush_i) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                mem_q[i].killed <= 1'b1;
            end
        end
        if (push_i) begin
            mem_q[wr_ptr_q]        <= entry_i;
            mem_q[wr_ptr_q].killed <= entry_i.killed | flush_i;
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full || pop)
        else $error("push into full load queue");

    // cache must not answer more loads than were granted
    assert property (@(posedge clk_i) disable iff (!rst_ni) data_rvalid_i |-> !empty_o)
        else $error("rvalid with no load outstanding");

endmodule

`default_nettype wire

// File: source/load_unit.sv
// load unit top
`timescale 1ns/1ps
`default_nettype none

module load_unit import load_pkg::*; #(
    parameter int unsigned QUEUE_DEPTH = 2
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    // issue side
    input  load_req_t       req_i,
    input  logic            valid_i,
    output logic            ready_o,
    // writeback side
    output logic            valid_o,
    output load_resp_t      resp_o,
    // mmu
    output logic            translation_req_o,
    output logic [XLEN-1:0] vaddr_o,
    input  logic [XLEN-1:0] paddr_i,
    input  logic            translation_valid_i,
    // store check, compares against vaddr_o
    input  logic            page_offset_matches_i,
    // data cache
    output dcache_req_t     dcache_o,
    input  logic            data_gnt_i,
    input  logic            data_rvalid_i,
    input  logic [XLEN-1:0] data_rdata_i
);

    logic         push;
    logic         empty;
    queue_entry_t new_entry;
    queue_entry_t head;

    // virtual address goes straight to the mmu
    assign vaddr_o         = req_i.vaddr;
    assign resp_o.trans_id = head.trans_id;

    load_ctrl i_ctrl (
        .clk_i                 ( clk_i                 ),
        .rst_ni                ( rst_ni                ),
        .flush_i               ( flush_i               ),
        .req_i                 ( req_i                 ),
        .valid_i               ( valid_i               ),
        .ready_o               ( ready_o               ),
        .translation_req_o     ( translation_req_o     ),
        .paddr_i               ( paddr_i               ),
        .translation_valid_i   ( translation_valid_i   ),
        .page_offset_matches_i ( page_offset_matches_i ),
        .dcache_o              ( dcache_o              ),
        .data_gnt_i            ( data_gnt_i            ),
        .data_rvalid_i         ( data_rvalid_i         ),
        .push_o                ( push                  ),
        .entry_o               ( new_entry             ),
        .empty_i               ( empty                 )
    );

    load_queue #(
        .QUEUE_DEPTH ( QUEUE_DEPTH )
    ) i_queue (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .flush_i       ( flush_i       ),
        .push_i        ( push          ),
        .entry_i       ( new_entry     ),
        .data_rvalid_i ( data_rvalid_i ),
        .head_o        ( head          ),
        .empty_o       ( empty         ),
        .valid_o       ( valid_o       )
    );

    // head entry decides how the returned word is cut
    load_align i_align (
        .head_i       ( head          ),
        .data_rdata_i ( data_rdata_i  ),
        .result_o     ( resp_o.result )
    );

endmodule

`default_nettype wire
